// File: bench/core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module core_tb import rv_pkg::*; ();

  localparam int    num_insns    = 200;
  localparam int    mem_words    = 256;
  localparam int    halt_timeout = 400;
  localparam word_t ecall_word   = 32'h0000_0073;

  logic   clk = 1'b0;
  logic   rst;
  word_t  pc_to_imem;
  word_t  insn_from_imem;
  logic   halt;
  trace_t trace;

  // program image plus the per-slot values from the shadow model
  word_t imem     [0:mem_words-1];
  word_t exp_rd   [0:mem_words-1];
  logic  exp_halt [0:mem_words-1];
  word_t shadow   [0:7];

  logic [15:0] lfsr_state = 16'd22;
  int          post_cnt = 0;
  int          reset_cycles = 0;
  logic [7:0]  retire_idx;
  word_t       pc_hist [0:3];

  // 16 bit galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input word_t expected, input word_t actual);
    $display("error %s expected %h actual %h", test, expected, actual);
    abort_run();
  endtask

  // random lui/addi/add/sub over x0..x7, then ecalls to the end of memory
  task automatic build_program();
    logic [31:0] v;
    logic [1:0]  op;
    logic [2:0]  rd;
    logic [2:0]  rs1;
    logic [2:0]  rs2;
    logic [6:0]  funct7;
    word_t       result;
    for (int r = 0; r < 8; r++) begin
      shadow[r] = '0;
    end
    for (int i = 0; i < mem_words; i++) begin
      if (i >= num_insns) begin
        imem[i[7:0]] = ecall_word;
        exp_rd[i[7:0]] = '0;
        exp_halt[i[7:0]] = 1'b1;
      end else begin
        draw_bits(2, v);
        op = v[1:0];
        draw_bits(3, v);
        rd = v[2:0];
        draw_bits(3, v);
        rs1 = v[2:0];
        if (op == 2'd0) begin
          draw_bits(20, v);
          imem[i[7:0]] = {v[19:0], 2'b00, rd, opcode_lui};
          result = {v[19:0], 12'h000};
        end else if (op == 2'd1) begin
          draw_bits(12, v);
          imem[i[7:0]] = {v[11:0], 2'b00, rs1, 3'b000, 2'b00, rd, opcode_reg_imm};
          result = shadow[rs1] + {{20{v[11]}}, v[11:0]};
        end else begin
          draw_bits(3, v);
          rs2 = v[2:0];
          funct7 = (op == 2'd3) ? 7'b0100000 : 7'b0000000;
          imem[i[7:0]] = {funct7, 2'b00, rs2, 2'b00, rs1, 3'b000, 2'b00, rd, opcode_reg_reg};
          result = (op == 2'd3) ? shadow[rs1] - shadow[rs2] : shadow[rs1] + shadow[rs2];
        end
        // x0 keeps its zero and the retired value shows as 0
        if (rd == 3'd0) begin
          result = '0;
        end else begin
          shadow[rd] = result;
        end
        exp_rd[i[7:0]] = result;
        exp_halt[i[7:0]] = 1'b0;
      end
    end
  endtask

  function automatic word_t fetch_word(word_t addr);
    if (addr[31:10] != '0) begin
      return ecall_word;
    end else begin
      return imem[addr[9:2]];
    end
  endfunction

  always #5 clk = ~clk;

  riscv_core u_dut (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .halt           (halt),
    .trace          (trace)
  );

  // instruction memory answers on the falling edge
  always @(negedge clk) begin
    insn_from_imem = fetch_word(pc_to_imem);
  end

  always @(posedge clk) begin
    if (rst) begin
      post_cnt <= 0;
      reset_cycles <= reset_cycles + 1;
    end else begin
      post_cnt <= post_cnt + 1;
    end
    pc_hist[0] <= pc_to_imem;
    for (int h = 1; h < 4; h++) begin
      pc_hist[h] <= pc_hist[h-1];
    end
  end

  // program slot now in writeback
  assign retire_idx = 8'(post_cnt - 4);

  reset_status: assert property (@(posedge clk) disable iff (rst)
    post_cnt < 4 |-> trace.cycle_status == cycle_reset)
    else report_mismatch("reset_status", 32'(cycle_reset), 32'($sampled(trace.cycle_status)));

  reset_pc: assert property (@(posedge clk) disable iff (rst)
    post_cnt < 4 |-> trace.pc == '0)
    else report_mismatch("reset_pc", '0, $sampled(trace.pc));

  reset_insn: assert property (@(posedge clk) disable iff (rst)
    post_cnt < 4 |-> trace.insn == '0)
    else report_mismatch("reset_insn", '0, $sampled(trace.insn));

  reset_rd_data: assert property (@(posedge clk) disable iff (rst)
    post_cnt < 4 |-> trace.rd_data == '0)
    else report_mismatch("reset_rd_data", '0, $sampled(trace.rd_data));

  run_status: assert property (@(posedge clk) disable iff (rst)
    post_cnt >= 4 |-> trace.cycle_status == cycle_no_stall)
    else report_mismatch("run_status", 32'(cycle_no_stall), 32'($sampled(trace.cycle_status)));

  pc_sequence: assert property (@(posedge clk) disable iff (rst)
    pc_to_imem == 32'(post_cnt * 4))
    else report_mismatch("pc_sequence", 32'($sampled(post_cnt) * 4), $sampled(pc_to_imem));

  trace_pc: assert property (@(posedge clk) disable iff (rst)
    post_cnt >= 4 |-> trace.pc == pc_hist[3])
    else report_mismatch("trace_pc", $sampled(pc_hist[3]), $sampled(trace.pc));

  trace_insn: assert property (@(posedge clk) disable iff (rst)
    post_cnt >= 4 |-> trace.insn == imem[retire_idx])
    else report_mismatch("trace_insn", imem[$sampled(retire_idx)], $sampled(trace.insn));

  result_value: assert property (@(posedge clk) disable iff (rst)
    post_cnt >= 4 |-> trace.rd_data == exp_rd[retire_idx])
    else report_mismatch("result_value", exp_rd[$sampled(retire_idx)], $sampled(trace.rd_data));

  x0_not_written: assert property (@(posedge clk) disable iff (rst)
    post_cnt >= 4 && trace.insn.r.rd == '0 |-> trace.rd_data == '0)
    else report_mismatch("x0_not_written", '0, $sampled(trace.rd_data));

  halt_timing: assert property (@(posedge clk) disable iff (rst)
    post_cnt >= 4 |-> halt == exp_halt[retire_idx])
    else report_mismatch("halt_timing", 32'(exp_halt[$sampled(retire_idx)]), 32'($sampled(halt)));

  halt_early: assert property (@(posedge clk) disable iff (rst)
    post_cnt < 4 |-> !halt)
    else report_mismatch("halt_early", '0, 32'($sampled(halt)));

  // first edge of reset still sees unreset state
  halt_in_reset: assert property (@(posedge clk)
    rst && reset_cycles > 0 |-> !halt)
    else report_mismatch("halt_in_reset", '0, 32'($sampled(halt)));

  initial begin
    int waited;
    rst = 1'b1;
    insn_from_imem = '0;
    build_program();
    repeat (10) @(negedge clk);
    rst = 1'b0;
    waited = 0;
    while (!halt && waited < halt_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (!halt) begin
      $display("halt did not rise within %0d cycles after reset", halt_timeout);
      abort_run();
    end else begin
      // trailing ecalls keep halt high
      repeat (4) @(negedge clk);
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: logic/alu.sv
`default_nettype none
`timescale 1ns/1ps

module alu import rv_pkg::*; (
  input  insn_t insn,
  input  word_t a,
  input  word_t b,
  output word_t o
);

  word_t imm_i;
  word_t imm_u;

  // sign-extended 12 bit immediate for addi
  assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};

  // lui places its immediate in the upper 20 bits
  assign imm_u = {insn.u.imm, 12'd0};

  always_comb begin
    o = '0;
    case (insn.r.opcode)
      opcode_lui: begin
        o = imm_u;
      end
      opcode_reg_imm: begin
        if (insn.i.funct3 == funct3_add) begin
          o = a + imm_i;
        end
      end
      opcode_reg_reg: begin
        if (insn.r.funct3 == funct3_add) begin
          // funct7 bit 5 picks sub over add
          if (insn.r.funct7 == funct7_sub) begin
            o = a - b;
          end else begin
            o = a + b;
          end
        end
      end
      default: begin
        o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/decode_unit.sv
`default_nettype none
`timescale 1ns/1ps

module decode_unit import rv_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  stage_decode_t  decode_state,
  output reg_addr_t      rs1,
  output reg_addr_t      rs2,
  input  word_t          rs1_data,
  input  word_t          rs2_data,
  input  reg_addr_t      wb_rd,
  input  word_t          wb_data,
  input  logic           wb_we,
  output stage_execute_t execute_state
);

  word_t a;
  word_t b;
  logic  bypass_a;
  logic  bypass_b;

  // source fields sit in the same place for every format
  assign rs1 = decode_state.insn.r.rs1;
  assign rs2 = decode_state.insn.r.rs2;

  // write-through, the value retiring now is not yet in the array
  assign bypass_a = wb_we && wb_rd != '0 && wb_rd == rs1;
  assign bypass_b = wb_we && wb_rd != '0 && wb_rd == rs2;

  assign a = bypass_a ? wb_data : rs1_data;
  assign b = bypass_b ? wb_data : rs2_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_state <= '{
        pc: '0,
        insn: '0,
        a: '0,
        b: '0,
        cycle_status: cycle_reset
      };
    end else begin
      execute_state <= '{
        pc: decode_state.pc,
        insn: decode_state.insn,
        a: a,
        b: b,
        cycle_status: decode_state.cycle_status
      };
    end
  end

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`default_nettype none
`timescale 1ns/1ps

module execute_unit import rv_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  stage_execute_t execute_state,
  input  reg_addr_t      mem_rd,
  input  reg_addr_t      wb_rd,
  input  word_t          mem_data,
  input  word_t          wb_data,
  output stage_memory_t  memory_state
);

  reg_addr_t src1;
  reg_addr_t src2;
  word_t     op_a;
  word_t     op_b;
  word_t     alu_o;

  assign src1 = execute_state.insn.r.rs1;
  assign src2 = execute_state.insn.r.rs2;

  // the younger producer in memory wins over the one in writeback
  always_comb begin
    if (mem_rd != '0 && mem_rd == src1) begin
      op_a = mem_data;
    end else if (wb_rd != '0 && wb_rd == src1) begin
      op_a = wb_data;
    end else begin
      op_a = execute_state.a;
    end

    if (mem_rd != '0 && mem_rd == src2) begin
      op_b = mem_data;
    end else if (wb_rd != '0 && wb_rd == src2) begin
      op_b = wb_data;
    end else begin
      op_b = execute_state.b;
    end
  end

  alu u_alu (
    .insn (execute_state.insn),
    .a    (op_a),
    .b    (op_b),
    .o    (alu_o)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      memory_state <= '{pc: '0, insn: '0, o: '0, cycle_status: cycle_reset};
    end else begin
      memory_state <= '{
        pc: execute_state.pc,
        insn: execute_state.insn,
        o: alu_o,
        cycle_status: execute_state.cycle_status
      };
    end
  end

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_unit import rv_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  output word_t         pc_to_imem,
  input  word_t         insn_from_imem,
  output stage_decode_t decode_state
);

  word_t pc;

  // no branches, so the pc only ever steps forward
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  assign pc_to_imem = pc;

  // imem answers within the cycle, so the word is latched with its pc
  always_ff @(posedge clk) begin
    if (rst) begin
      decode_state <= '{pc: '0, insn: '0, cycle_status: cycle_reset};
    end else begin
      decode_state <= '{pc: pc, insn: insn_from_imem, cycle_status: cycle_no_stall};
    end
  end

  // imem only takes word aligned addresses
  pc_aligned: assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      we,
  input  reg_addr_t rd,
  input  word_t     rd_data
);

  // x0 has no storage
  word_t regs [1:num_regs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // a write shows on the read ports one cycle later, one aimed at x0 never does
  write_read_back: assert property (@(posedge clk) disable iff (rst)
    we |=> (rs1 != $past(rd) || rs1_data == (($past(rd) == '0) ? '0 : $past(rd_data)))
        && (rs2 != $past(rd) || rs2_data == (($past(rd) == '0) ? '0 : $past(rd_data))));

endmodule

`default_nettype wire

// File: logic/retire_unit.sv
`default_nettype none
`timescale 1ns/1ps

module retire_unit import rv_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  stage_memory_t memory_state,
  output reg_addr_t     mem_rd,
  output reg_addr_t     wb_rd,
  output word_t         mem_data,
  output word_t         wb_data,
  output logic          wb_we,
  output logic          halt,
  output trace_t        trace
);

  stage_memory_t writeback_state;

  // destination of a slot, zero for bubbles and anything that does not write
  function automatic reg_addr_t dest_of(stage_memory_t s);
    reg_addr_t d;
    d = '0;
    if (s.cycle_status == cycle_no_stall) begin
      case (s.insn.r.opcode)
        opcode_lui, opcode_reg_imm, opcode_reg_reg: d = s.insn.r.rd;
        default: d = '0;
      endcase
    end
    return d;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      writeback_state <= '{pc: '0, insn: '0, o: '0, cycle_status: cycle_reset};
    end else begin
      writeback_state <= memory_state;
    end
  end

  // bypass taps for execute
  assign mem_rd   = dest_of(memory_state);
  assign mem_data = memory_state.o;
  assign wb_rd    = dest_of(writeback_state);
  assign wb_data  = writeback_state.o;
  assign wb_we    = wb_rd != '0;

  // ecall is the environ opcode with every other field zero
  assign halt = writeback_state.cycle_status == cycle_no_stall
             && writeback_state.insn.i.opcode == opcode_environ
             && writeback_state.insn.i.imm == '0
             && writeback_state.insn.i.rs1 == '0
             && writeback_state.insn.i.funct3 == '0
             && writeback_state.insn.i.rd == '0;

  always_comb begin
    trace.pc           = writeback_state.pc;
    trace.insn         = writeback_state.insn;
    trace.rd_data      = wb_we ? writeback_state.o : '0;
    trace.cycle_status = writeback_state.cycle_status;
  end

  // every slot is tagged in fetch and must arrive here with a real status
  status_valid: assert property (@(posedge clk) disable iff (rst)
    writeback_state.cycle_status != cycle_invalid);

endmodule

`default_nettype wire

// File: logic/riscv_core.sv
`default_nettype none
`timescale 1ns/1ps

module riscv_core import rv_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  output word_t  pc_to_imem,
  input  word_t  insn_from_imem,
  output logic   halt,
  output trace_t trace
);

  stage_decode_t  decode_state;
  stage_execute_t execute_state;
  stage_memory_t  memory_state;

  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;

  reg_addr_t mem_rd;
  word_t     mem_data;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      wb_we;

  fetch_unit u_fetch (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .decode_state   (decode_state)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_we),
    .rd       (wb_rd),
    .rd_data  (wb_data)
  );

  decode_unit u_decode (
    .clk           (clk),
    .rst           (rst),
    .decode_state  (decode_state),
    .rs1           (rs1),
    .rs2           (rs2),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .wb_we         (wb_we),
    .execute_state (execute_state)
  );

  execute_unit u_execute (
    .clk           (clk),
    .rst           (rst),
    .execute_state (execute_state),
    .mem_rd        (mem_rd),
    .wb_rd         (wb_rd),
    .mem_data      (mem_data),
    .wb_data       (wb_data),
    .memory_state  (memory_state)
  );

  retire_unit u_retire (
    .clk          (clk),
    .rst          (rst),
    .memory_state (memory_state),
    .mem_rd       (mem_rd),
    .wb_rd        (wb_rd),
    .mem_data     (mem_data),
    .wb_data      (wb_data),
    .wb_we        (wb_we),
    .halt         (halt),
    .trace        (trace)
  );

endmodule

`default_nettype wire

// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int reg_width      = 32;
  localparam int reg_addr_width = 5;
  localparam int num_regs       = 32;

  typedef logic [reg_width-1:0]      word_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [6:0]                opcode_t;

  // base opcodes from the rv32i encoding table
  localparam opcode_t opcode_reg_imm = 7'b00_100_11;
  localparam opcode_t opcode_reg_reg = 7'b01_100_11;
  localparam opcode_t opcode_lui     = 7'b01_101_11;
  localparam opcode_t opcode_environ = 7'b11_100_11;

  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [6:0] funct7_sub = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_t     opcode;
  } i_type_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    opcode_t     opcode;
  } u_type_t;

  // one instruction word, read through whichever layout its opcode selects
  typedef union packed {
    r_type_t r;
    i_type_t i;
    u_type_t u;
  } insn_t;

  // status of the slot that reaches writeback
  typedef enum logic [1:0] {
    cycle_invalid  = 2'd0,
    cycle_reset    = 2'd1,
    cycle_no_stall = 2'd2
  } cycle_status_t;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_t cycle_status;
  } stage_decode_t;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    word_t         a;
    word_t         b;
    cycle_status_t cycle_status;
  } stage_execute_t;

  // also reused as the writeback stage register
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    word_t         o;
    cycle_status_t cycle_status;
  } stage_memory_t;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    word_t         rd_data;
    cycle_status_t cycle_status;
  } trace_t;

endpackage

`default_nettype wire

// File: project.f
logic/rv_pkg.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/alu.sv
logic/execute_unit.sv
logic/retire_unit.sv
logic/riscv_core.sv
bench/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the core testbench, then judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f project.f \
  -o core_tb_sim || { echo "build failed"; exit 1; }
./obj_dir/core_tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || grep -q "SIMULATION PASSED" sim.log || exit 1
